// File: project.f
logic/anchor_cull_pkg.sv
logic/fp16_to_fixed.sv
logic/view_transform.sv
logic/frustum_project.sv
logic/occlusion_test.sv
logic/anchor_cull_top.sv
verif/anchor_cull_assertions.sv
verif/anchor_cull_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the anchor culling testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module anchor_cull_tb -f project.f -o anchor_cull_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/anchor_cull_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: verif/anchor_cull_tb.sv
`timescale 1ns/10ps
`default_nettype none

module anchor_cull_tb;
    import anchor_cull_pkg::*;

    typedef struct {
        int cfg_sel, ax, ay, az;
        int word, entry, entry_val;
        int exp_read, exp_addr, exp_mask;
        int b2b;    // next row follows with no idle cycle
    } row_t;

    typedef struct {
        int strobe;
        int exp_read, exp_addr, exp_mask;
    } expect_t;

    typedef struct {
        int cyc;
        int addr;
    } read_t;

    localparam int NROWS = 12;

    logic                  clk;
    logic                  rstn;
    logic                  cfg_load_i;
    cull_cfg_t             cfg_i;
    logic                  anchor_valid_i;
    fp16_t [2:0]           anchor_i;
    logic [OCC_DATA_W-1:0] occl_rdata_i;
    occl_req_t             occl_req_o;
    logic                  mask_valid_o;
    logic                  mask_o;

    logic [OCC_DATA_W-1:0] occ_mem [64];
    row_t                  rows [NROWS];
    expect_t               exp_q [$];
    read_t                 read_q [$];
    int                    cyc;
    integer                seed;

    anchor_cull_top dut0 (
        .clk            (clk),
        .rstn           (rstn),
        .cfg_load_i     (cfg_load_i),
        .cfg_i          (cfg_i),
        .anchor_valid_i (anchor_valid_i),
        .anchor_i       (anchor_i),
        .occl_rdata_i   (occl_rdata_i),
        .occl_req_o     (occl_req_o),
        .mask_valid_o   (mask_valid_o),
        .mask_o         (mask_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // occlusion memory with one cycle of read latency
    always @(posedge clk) begin
        if (!occl_req_o.cen_n) begin
            occl_rdata_i <= occ_mem[occl_req_o.addr];
        end
    end

    task automatic check(input string what, input int got, input int exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    // whole numbers below 2048 in magnitude
    function automatic fp16_t int_to_fp16(input int v);
        int m;
        int p;
        m = (v < 0) ? -v : v;
        p = 0;
        if (m == 0) begin
            return 16'h0000;
        end
        for (int b = 0; b < 11; b++) begin
            if (((m >> b) & 1) == 1) p = b;
        end
        return {v < 0, 5'(p + 15), 10'((m << (10 - p)) & 'h3ff)};
    endfunction

    function automatic cull_cfg_t make_cfg(input int sel);
        cull_cfg_t c;
        c = '0;
        for (int r = 0; r < 3; r++) begin
            c.mat[r][r] = int_to_fp16(1);
        end
        if (sel == 1) begin
            c.mat[0][3] = int_to_fp16(5);   // translate x
            c.mat[1][3] = int_to_fp16(7);   // translate y
        end
        c.pdfx    = '{sign: 1'b0, mag: 15'd64};
        c.pdfy    = '{sign: 1'b0, mag: 15'd64};
        c.zblock  = '{sign: 1'b0, mag: 15'd64};
        c.block_x = 3'd1;
        c.block_y = 3'd1;
        c.delay   = 8'd5;
        return c;
    endfunction

    // cell = floor(80 + coord/z) - 20, addr = cy*3 + cx/7, sel = cx%7
    task automatic fill_table();
        rows[0]  = '{0,  -50,  -55, 1, 16, 3, 'h000, 1, 16, 1, 1};
        rows[1]  = '{0,  -49,  -55, 1, 16, 4, 'h106, 1, 16, 1, 1};   // depth equals z+delay
        rows[2]  = '{0,  -48,  -55, 1, 16, 5, 'h105, 1, 16, 0, 0};   // one short
        rows[3]  = '{0,  -30,  -55, 1,  0, 0, 'h1ff, 0,  0, 0, 0};   // x past block
        rows[4]  = '{0,  -61,  -55, 1,  0, 1, 'h1ff, 0,  0, 0, 0};   // x before block
        rows[5]  = '{0, -120, -100, 2, 30, 0, 'h107, 1, 30, 1, 1};
        rows[6]  = '{0, -108, -100, 2, 30, 6, 'h0ff, 1, 30, 1, 1};
        rows[7]  = '{0, -106, -100, 2, 31, 0, 'h103, 1, 31, 0, 0};   // next word
        rows[8]  = '{0,  -50,  -75, 1,  0, 2, 'h1ff, 0,  0, 0, 0};   // y out
        rows[9]  = '{1,  -50,  -55, 1, 38, 1, 'h10a, 1, 38, 1, 0};
        rows[10] = '{1,  -44,  -55, 1,  0, 3, 'h1ff, 0,  0, 0, 0};
        rows[11] = '{1,  -49,  -55, 1, 38, 2, 'h105, 1, 38, 0, 0};
    endtask

    task automatic wait_drain();
        for (int t = 0; t < 40 && exp_q.size() != 0; t++) begin
            @(posedge clk);
        end
        if (exp_q.size() != 0) fail_run("timeout: mask_valid_o did not arrive for all anchors");
    endtask

    task automatic load_cfg(input int sel);
        @(posedge clk);
        cfg_load_i <= 1'b1;
        cfg_i      <= make_cfg(sel);
        @(posedge clk);
        cfg_load_i <= 1'b0;
        repeat (3) @(posedge clk);   // matrix settles
    endtask

    always @(posedge clk) begin : monitor
        expect_t e;
        read_t   rd;
        if (rstn && !occl_req_o.cen_n) begin
            read_q.push_back('{cyc, int'(occl_req_o.addr)});
        end
        if (mask_valid_o) begin
            if (exp_q.size() == 0) fail_run("mask_valid_o high with no anchor in flight");
            e = exp_q.pop_front();
            check("mask latency", cyc - e.strobe, LATENCY);
            check("mask", int'(mask_o), e.exp_mask);
            if (e.exp_read != 0) begin
                if (read_q.size() == 0) fail_run("no read request seen for an in-frustum anchor");
                rd = read_q.pop_front();
                check("read cycle", rd.cyc - e.strobe, 8);
                check("read address", rd.addr, e.exp_addr);
            end else if (read_q.size() != 0) begin
                check("read for culled anchor", int'(read_q[0].cyc <= e.strobe + 8), 0);
            end
        end
    end

    initial begin
        int cur_cfg;
        int gap;
        clk            = 1'b0;
        rstn           = 1'b0;
        cfg_load_i     = 1'b0;
        cfg_i          = '0;
        anchor_valid_i = 1'b0;
        anchor_i       = '0;
        occl_rdata_i   = '0;
        cyc            = 0;
        seed           = 32'h758c2eb0;
        cur_cfg        = -1;
        for (int a = 0; a < 64; a++) begin
            occ_mem[a] = {8{2'b10, 6'(a)}};
        end
        fill_table();
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        for (int i = 0; i < NROWS; i++) begin
            if (rows[i].cfg_sel != cur_cfg) begin
                @(posedge clk);
                anchor_valid_i <= 1'b0;
                wait_drain();
                load_cfg(rows[i].cfg_sel);
                cur_cfg = rows[i].cfg_sel;
            end
            @(posedge clk);
            anchor_valid_i <= 1'b1;
            anchor_i <= {int_to_fp16(rows[i].az), int_to_fp16(rows[i].ay),
                         int_to_fp16(rows[i].ax)};
            occ_mem[rows[i].word][9*rows[i].entry +: 9] <= 9'(rows[i].entry_val);
            exp_q.push_back('{cyc + 1, rows[i].exp_read, rows[i].exp_addr, rows[i].exp_mask});
            gap = (rows[i].b2b != 0) ? 0 : int'($unsigned($random(seed)) % 4);
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                anchor_valid_i <= 1'b0;
            end
        end
        @(posedge clk);
        anchor_valid_i <= 1'b0;
        wait_drain();
        repeat (2) @(posedge clk);

        if (read_q.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            fail_run("unexpected read requests left over");
        end
    end

endmodule

`default_nettype wire

// File: verif/anchor_cull_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module anchor_cull_assertions (
    input wire logic                       clk,
    input wire logic                       rstn,
    input wire logic                       anchor_valid_i,
    input wire logic                       mask_valid_o,
    input wire logic                       mask_o,
    input wire anchor_cull_pkg::occl_req_t occl_req_o
);
    import anchor_cull_pkg::*;

    a_mask_follows: assert property (@(posedge clk) disable iff (!rstn)
        $past(anchor_valid_i, LATENCY) |-> mask_valid_o)
        else $error("mask_valid_o missing LATENCY cycles after an anchor");

    a_mask_has_anchor: assert property (@(posedge clk) disable iff (!rstn)
        mask_valid_o |-> $past(anchor_valid_i, LATENCY))
        else $error("mask_valid_o without an anchor LATENCY cycles before");

    // checked mid-cycle, reset has taken effect by then
    a_no_read_in_reset: assert property (@(negedge clk)
        !rstn |-> occl_req_o.cen_n)
        else $error("occlusion read during reset");

    a_mask_qualified: assert property (@(posedge clk)
        mask_o |-> mask_valid_o)
        else $error("mask_o high without mask_valid_o");

endmodule

bind anchor_cull_top anchor_cull_assertions u_checks (
    .clk            (clk),
    .rstn           (rstn),
    .anchor_valid_i (anchor_valid_i),
    .mask_valid_o   (mask_valid_o),
    .mask_o         (mask_o),
    .occl_req_o     (occl_req_o)
);

`default_nettype wire

// File: logic/anchor_cull_top.sv
`timescale 1ns/10ps
`default_nettype none

module anchor_cull_top #(
    parameter int FRAC   = anchor_cull_pkg::FRAC_W,
    parameter int DATA_W = anchor_cull_pkg::OCC_DATA_W,
    parameter int CELLS  = anchor_cull_pkg::CELLS_PER_WORD,
    parameter int WORDS  = anchor_cull_pkg::WORDS_PER_ROW
) (
    input  wire logic                             clk,
    input  wire logic                             rstn,
    input  wire logic                             cfg_load_i,
    input  wire anchor_cull_pkg::cull_cfg_t       cfg_i,
    input  wire logic                             anchor_valid_i,
    input  wire anchor_cull_pkg::fp16_t [2:0]     anchor_i,   // x, y, z
    input  wire logic [DATA_W-1:0]                occl_rdata_i,
    output anchor_cull_pkg::occl_req_t            occl_req_o,
    output logic                                  mask_valid_o,
    output logic                                  mask_o
);
    import anchor_cull_pkg::*;

    cull_cfg_t        cfg_q;
    view_mat_t        mat_conv;
    view_mat_t        mat_q;
    fix_t [2:0]       anchor_fix;
    point_t           pt_conv;
    logic             conv_valid;
    point_t           pt_view;
    logic             view_valid;
    logic             proj_valid;
    logic [FIX_W-1:0] cell_x, cell_y;
    logic [7:0]       z_cell;
    logic             in_frustum;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cfg_q      <= '0;
            mat_q      <= '0;
            conv_valid <= 1'b0;
        end else begin
            if (cfg_load_i) begin
                cfg_q <= cfg_i;
            end
            mat_q      <= mat_conv;   // settled 2 cycles after the load
            conv_valid <= anchor_valid_i;
        end
    end

    for (genvar r = 0; r < 3; r++) begin : g_mat_row
        for (genvar c = 0; c < 4; c++) begin : g_mat_col
            fp16_to_fixed #(.FRAC(FRAC)) u_mat_cvt (
                .clk   (clk),
                .rstn  (rstn),
                .fp_i  (cfg_q.mat[r][c]),
                .fix_o (mat_conv[r][c])
            );
        end
    end

    for (genvar i = 0; i < 3; i++) begin : g_coord
        fp16_to_fixed #(.FRAC(FRAC)) u_coord_cvt (
            .clk   (clk),
            .rstn  (rstn),
            .fp_i  (anchor_i[i]),
            .fix_o (anchor_fix[i])
        );
    end

    assign pt_conv = '{x: anchor_fix[0], y: anchor_fix[1], z: anchor_fix[2]};

    view_transform u_view (
        .clk     (clk),
        .rstn    (rstn),
        .valid_i (conv_valid),
        .pt_i    (pt_conv),
        .mat_i   (mat_q),
        .valid_o (view_valid),
        .pt_o    (pt_view)
    );

    frustum_project u_proj (
        .clk          (clk),
        .rstn         (rstn),
        .valid_i      (view_valid),
        .pt_i         (pt_view),
        .pdfx_i       (cfg_q.pdfx),
        .pdfy_i       (cfg_q.pdfy),
        .zblock_i     (cfg_q.zblock),
        .block_x_i    (cfg_q.block_x),
        .block_y_i    (cfg_q.block_y),
        .valid_o      (proj_valid),
        .cell_x_o     (cell_x),
        .cell_y_o     (cell_y),
        .z_cell_o     (z_cell),
        .in_frustum_o (in_frustum)
    );

    occlusion_test #(
        .DATA_W (DATA_W),
        .CELLS  (CELLS),
        .WORDS  (WORDS)
    ) u_occl (
        .clk          (clk),
        .rstn         (rstn),
        .valid_i      (proj_valid),
        .cell_x_i     (cell_x),
        .cell_y_i     (cell_y),
        .z_cell_i     (z_cell),
        .in_frustum_i (in_frustum),
        .delay_i      (cfg_q.delay),
        .occl_rdata_i (occl_rdata_i),
        .occl_req_o   (occl_req_o),
        .mask_valid_o (mask_valid_o),
        .mask_o       (mask_o)
    );

endmodule

`default_nettype wire

// File: logic/occlusion_test.sv
`timescale 1ns/10ps
`default_nettype none

module occlusion_test #(
    parameter int DATA_W = anchor_cull_pkg::OCC_DATA_W,
    parameter int CELLS  = anchor_cull_pkg::CELLS_PER_WORD,
    parameter int WORDS  = anchor_cull_pkg::WORDS_PER_ROW
) (
    input  wire logic                               clk,
    input  wire logic                               rstn,
    input  wire logic                               valid_i,
    input  wire logic [anchor_cull_pkg::FIX_W-1:0]  cell_x_i,
    input  wire logic [anchor_cull_pkg::FIX_W-1:0]  cell_y_i,
    input  wire logic [7:0]                         z_cell_i,
    input  wire logic                               in_frustum_i,
    input  wire logic [7:0]                         delay_i,
    input  wire logic [DATA_W-1:0]                  occl_rdata_i,
    output anchor_cull_pkg::occl_req_t              occl_req_o,
    output logic                                    mask_valid_o,
    output logic                                    mask_o
);
    import anchor_cull_pkg::*;

    localparam int SEL_W = $clog2(CELLS);

    logic                    cen_n_q;
    logic [OCC_ADDR_W-1:0]   addr_q;
    logic [SEL_W-1:0]        sel_a_q, sel_b_q;
    logic [7:0]              z_a_q, z_b_q;
    logic                    valid_a_q, valid_b_q;
    logic                    hit_b_q;
    occl_entry_t [CELLS-1:0] entries;
    occl_entry_t             entry;
    logic                    depth_ok;

    // address register, then the memory cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cen_n_q   <= 1'b1;
            valid_a_q <= 1'b0;
            valid_b_q <= 1'b0;
            hit_b_q   <= 1'b0;
        end else begin
            cen_n_q   <= !(valid_i && in_frustum_i);   // no read when culled
            valid_a_q <= valid_i;
            valid_b_q <= valid_a_q;
            hit_b_q   <= !cen_n_q;
        end
    end

    always_ff @(posedge clk) begin
        addr_q  <= OCC_ADDR_W'(cell_y_i * WORDS + cell_x_i / CELLS);
        sel_a_q <= SEL_W'(cell_x_i % CELLS);
        z_a_q   <= z_cell_i;
        sel_b_q <= sel_a_q;
        z_b_q   <= z_a_q;
    end

    assign occl_req_o = '{cen_n: cen_n_q, addr: addr_q};

    // entry k sits at bits 9k+8:9k
    assign entries  = occl_rdata_i[CELLS*$bits(occl_entry_t)-1:0];
    assign entry    = entries[sel_b_q];
    assign depth_ok = {1'b0, entry.depth} >= ({1'b0, z_b_q} + {1'b0, delay_i});

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mask_valid_o <= 1'b0;
            mask_o       <= 1'b0;
        end else begin
            mask_valid_o <= valid_b_q;
            mask_o       <= hit_b_q && (!entry.valid || depth_ok);
        end
    end

endmodule

`default_nettype wire

// File: logic/frustum_project.sv
`timescale 1ns/10ps
`default_nettype none

module frustum_project (
    input  wire logic                               clk,
    input  wire logic                               rstn,
    input  wire logic                               valid_i,
    input  wire anchor_cull_pkg::point_t            pt_i,
    input  wire anchor_cull_pkg::fix_t              pdfx_i,
    input  wire anchor_cull_pkg::fix_t              pdfy_i,
    input  wire anchor_cull_pkg::fix_t              zblock_i,
    input  wire logic [2:0]                         block_x_i,
    input  wire logic [2:0]                         block_y_i,
    output logic                                    valid_o,
    output logic [anchor_cull_pkg::FIX_W-1:0]       cell_x_o,
    output logic [anchor_cull_pkg::FIX_W-1:0]       cell_y_o,
    output logic [7:0]                              z_cell_o,
    output logic                                    in_frustum_o
);
    import anchor_cull_pkg::*;

    fix_t       xd_q, yd_q;
    fix_t       xm_q, ym_q;
    fix_t       xp_q, yp_q, zp_q;
    fix_t [1:0] z_dly_q;
    logic [2:0] valid_q;
    fix_t       x_lo, x_hi;
    fix_t       y_lo, y_hi;
    logic       x_in, y_in, z_in;

    // corner of sub-block idx along one axis
    function automatic fix_t block_edge(input logic [3:0] idx);
        return '{sign: 1'b0, mag: 15'(idx * SUB_SPAN.mag)};
    endfunction

    always_ff @(posedge clk) begin
        xd_q    <= sm_div(pt_i.x, pt_i.z);
        yd_q    <= sm_div(pt_i.y, pt_i.z);
        z_dly_q <= {z_dly_q[0], pt_i.z};
        xm_q    <= sm_mul(xd_q, pdfx_i);
        ym_q    <= sm_mul(yd_q, pdfy_i);
        xp_q    <= sm_add(xm_q, GRID_CENTER);
        yp_q    <= sm_add(ym_q, GRID_CENTER);
        zp_q    <= sm_div(z_dly_q[1], zblock_i);   // lines up with xp, yp
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[1:0], valid_i};
        end
    end

    assign x_lo = block_edge({1'b0, block_x_i});
    assign x_hi = block_edge({1'b0, block_x_i} + 4'd1);
    assign y_lo = block_edge({1'b0, block_y_i});
    assign y_hi = block_edge({1'b0, block_y_i} + 4'd1);

    assign x_in = sm_ge(xp_q, x_lo) && !sm_ge(xp_q, x_hi);
    assign y_in = sm_ge(yp_q, y_lo) && !sm_ge(yp_q, y_hi);
    assign z_in = sm_ge(zp_q, '0) && !sm_ge(zp_q, GRID_CENTER);

    assign valid_o      = valid_q[2];
    assign in_frustum_o = x_in && y_in && z_in;

    // floor, then relative to sub-block corner
    assign cell_x_o = FIX_W'(xp_q.mag >> FRAC_W) - FIX_W'(x_lo.mag >> FRAC_W);
    assign cell_y_o = FIX_W'(yp_q.mag >> FRAC_W) - FIX_W'(y_lo.mag >> FRAC_W);
    assign z_cell_o = zp_q.mag[FRAC_W+7:FRAC_W];

endmodule

`default_nettype wire

// File: logic/view_transform.sv
`timescale 1ns/10ps
`default_nettype none

module view_transform (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic                       valid_i,
    input  wire anchor_cull_pkg::point_t    pt_i,
    input  wire anchor_cull_pkg::view_mat_t mat_i,
    output logic                            valid_o,
    output anchor_cull_pkg::point_t         pt_o
);
    import anchor_cull_pkg::*;

    fix_t [3:0]      coord;
    fix_t [2:0][3:0] prod_q;
    fix_t [2:0][1:0] pair_q;
    fix_t [2:0]      row;
    logic [2:0]      valid_q;

    assign coord = {FIX_ONE, pt_i.z, pt_i.y, pt_i.x};   // homogeneous w = 1.0

    // products, pairwise sums
    always_ff @(posedge clk) begin
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 4; c++) begin
                prod_q[r][c] <= sm_mul(mat_i[r][c], coord[c]);
            end
            pair_q[r][0] <= sm_add(prod_q[r][0], prod_q[r][1]);
            pair_q[r][1] <= sm_add(prod_q[r][2], prod_q[r][3]);
        end
    end

    always_comb begin
        for (int r = 0; r < 3; r++) begin
            row[r] = sm_add(pair_q[r][0], pair_q[r][1]);
        end
    end

    always_ff @(posedge clk) begin
        pt_o <= '{x: row[0], y: row[1], z: row[2]};
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[1:0], valid_i};
        end
    end

    assign valid_o = valid_q[2];

endmodule

`default_nettype wire

// File: logic/fp16_to_fixed.sv
`timescale 1ns/10ps
`default_nettype none

module fp16_to_fixed #(
    parameter int FRAC = anchor_cull_pkg::FRAC_W
) (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire logic [15:0]      fp_i,
    output anchor_cull_pkg::fix_t fix_o
);

    localparam int BIAS = 15 + 10 - FRAC;   // exp bias plus mantissa bits, less frac

    logic [4:0]  exp_f;
    logic [10:0] mant;
    logic [25:0] aligned;
    logic [14:0] mag_sat;

    assign exp_f = fp_i[14:10];
    assign mant  = (exp_f == 5'd0) ? {1'b0, fp_i[9:0]} : {1'b1, fp_i[9:0]};   // denormal

    always_comb begin
        if (exp_f >= BIAS) begin
            aligned = 26'(mant) << (exp_f - BIAS);
        end else begin
            aligned = 26'(mant) >> (BIAS - exp_f);
        end
        if (aligned[25:15] != '0) begin
            mag_sat = 15'h7fff;
        end else begin
            mag_sat = aligned[14:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            fix_o <= '0;
        end else begin
            fix_o <= '{sign: fp_i[15], mag: mag_sat};
        end
    end

endmodule

`default_nettype wire

// File: logic/anchor_cull_pkg.sv
`default_nettype none

package anchor_cull_pkg;

    localparam int FIX_W          = 16;
    localparam int FRAC_W         = 6;
    localparam int CELLS_PER_WORD = 7;
    localparam int WORDS_PER_ROW  = 3;
    localparam int OCC_ADDR_W     = 6;
    localparam int OCC_DATA_W     = 64;
    localparam int LATENCY        = 10;   // anchor strobe to mask

    typedef logic [15:0] fp16_t;

    // sign-magnitude, 6 fraction bits
    typedef struct packed {
        logic             sign;
        logic [FIX_W-2:0] mag;
    } fix_t;

    localparam fix_t FIX_ONE     = '{sign: 1'b0, mag: 15'(1 << FRAC_W)};
    localparam fix_t GRID_CENTER = '{sign: 1'b0, mag: 15'(80 << FRAC_W)};
    localparam fix_t SUB_SPAN    = '{sign: 1'b0, mag: 15'(20 << FRAC_W)};

    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
    } point_t;

    typedef fix_t  [2:0][3:0] view_mat_t;    // [row][col]
    typedef fp16_t [2:0][3:0] fp16_mat_t;

    typedef struct packed {
        fp16_mat_t  mat;
        fix_t       pdfx;
        fix_t       pdfy;
        fix_t       zblock;
        logic [2:0] block_x;
        logic [2:0] block_y;
        logic [7:0] delay;     // depth margin
    } cull_cfg_t;

    typedef struct packed {
        logic                  cen_n;
        logic [OCC_ADDR_W-1:0] addr;
    } occl_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] depth;
    } occl_entry_t;

    function automatic fix_t sm_mul(input fix_t a, input fix_t b);
        logic [2*(FIX_W-1)-1:0] prod;
        prod = a.mag * b.mag;
        return '{sign: a.sign ^ b.sign, mag: prod[FIX_W-2+FRAC_W:FRAC_W]};
    endfunction

    function automatic fix_t sm_div(input fix_t a, input fix_t b);
        logic [FIX_W-2+FRAC_W:0] num;
        logic [FIX_W-2+FRAC_W:0] quo;
        num = {a.mag, {FRAC_W{1'b0}}};
        if (b.mag == '0) begin
            quo = '1;   // divide by zero saturates
        end else begin
            quo = num / b.mag;
        end
        return '{sign: a.sign ^ b.sign, mag: quo[FIX_W-2:0]};
    endfunction

    function automatic fix_t sm_add(input fix_t a, input fix_t b);
        fix_t sum;
        if (a.sign == b.sign) begin
            sum = '{sign: a.sign, mag: a.mag + b.mag};
        end else if (a.mag >= b.mag) begin
            sum = '{sign: a.sign, mag: a.mag - b.mag};
        end else begin
            sum = '{sign: b.sign, mag: b.mag - a.mag};
        end
        return sum;
    endfunction

    function automatic logic sm_ge(input fix_t a, input fix_t b);
        logic ge;
        case ({a.sign, b.sign})
            2'b00:   ge = (a.mag >= b.mag);
            2'b11:   ge = (a.mag <= b.mag);
            2'b01:   ge = 1'b1;
            default: ge = (a.mag == '0) && (b.mag == '0);   // -0 equals +0
        endcase
        return ge;
    endfunction

endpackage

`default_nettype wire
